// ==== Bender.yml ====
package:
  name: mbu

sources:
  - design/mbu_pkg.sv
  - design/mbu_decoder.sv
  - design/mbu_addr_select.sv
  - design/mbu_regfile.sv
  - design/mbu_output.sv
  - design/mbu.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/mbu_asserts.sv
      - tests/mbu_tb.sv

// ==== design/mbu.sv ====
// Memory bank unit top level
// Decoder, index select, bank registers and output stage

`timescale 1ns/1ps

module mbu
   import mbu_pkg::*;
(
   input  logic              clk4,
   input  logic              reset,
   // Microcode addresses, IR and auto-index request
   input  cu_bus_t           cu,
   // Address bus window and I/O strobes
   input  io_bus_t           io,
   // Internal bus data for register writes
   input  logic [DATA_W-1:0] wr_data,
   input  logic              fp_ram_rom,
   output logic [DATA_W-1:0] aext,
   output logic [DATA_W-1:0] ibus_data,
   output logic              ibus_drive,
   output logic [DATA_W-1:0] db_data,
   output logic              db_drive
);

   mbu_strobes_t      strobes;
   logic              wr_en;
   reg_idx_t          wr_idx;
   reg_idx_t          rd_idx;
   reg_idx_t          ab_idx;
   logic [DATA_W-1:0] rd_data;

   // Register number inside the I/O window
   assign ab_idx = io.ab[IDX_W-1:0];

   ////////////////////
   // Decoding
   ////////////////////

   mbu_decoder u_decoder (
      .cu      (cu),
      .io      (io),
      .strobes (strobes)
   );

   ////////////////////
   // Register file
   ////////////////////

   mbu_addr_select u_addr_select (
      .clk4    (clk4),
      .reset   (reset),
      .strobes (strobes),
      .cu      (cu),
      .ab_idx  (ab_idx),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .rd_idx  (rd_idx)
   );

   mbu_regfile u_regfile (
      .clk4    (clk4),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .rd_idx  (rd_idx),
      .wr_data (wr_data),
      .rd_data (rd_data)
   );

   ////////////////////
   // Outputs
   ////////////////////

   mbu_output u_output (
      .clk4       (clk4),
      .reset      (reset),
      .strobes    (strobes),
      .io_r       (io.r),
      .rd_data    (rd_data),
      .fp_ram_rom (fp_ram_rom),
      .aext       (aext),
      .ibus_data  (ibus_data),
      .ibus_drive (ibus_drive),
      .db_data    (db_data),
      .db_drive   (db_drive)
   );

endmodule

// ==== design/mbu_addr_select.sv ====
// MBU register index selection
// Auto-index flag, write enable and index, read index priority

`timescale 1ns/1ps

module mbu_addr_select
   import mbu_pkg::*;
(
   input  logic         clk4,
   input  logic         reset,
   input  mbu_strobes_t strobes,
   input  cu_bus_t      cu,
   input  reg_idx_t     ab_idx,
   output logic         wr_en,
   output reg_idx_t     wr_idx,
   output reg_idx_t     rd_idx
);

   ////////////////////
   // Auto-index flag
   ////////////////////

   logic ir_idx_q;

   // Sampled every edge, applies one cycle later
   always_ff @(posedge clk4) begin
      if (reset) begin
         ir_idx_q <= 1'b0;
      end else begin
         ir_idx_q <= cu.ir_idx;
      end
   end

   ////////////////////
   // Write side
   ////////////////////

   // Either OUT or write_mbp writes a register
   assign wr_en = strobes.io_wr | strobes.wr_mbp;

   // OUT wins over write_mbp in the same cycle
   always_comb begin
      if (strobes.io_wr) begin
         wr_idx = ab_idx;
      end else begin
         // MBP
         wr_idx = '0;
      end
   end

   ////////////////////
   // Read side
   ////////////////////

   reg_idx_t ar_idx;

   // write_ar index: 00 MBP, 01 MBD, 10 MBS, 11 MB3 or IR[2:0]
   always_comb begin
      case (cu.waddr.ar.sel)
         2'b00: ar_idx = 3'd0;
         2'b01: ar_idx = 3'd1;
         2'b10: ar_idx = 3'd2;
         default: begin
            if (ir_idx_q) begin
               ar_idx = cu.ir;
            end else begin
               ar_idx = 3'd3;
            end
         end
      endcase
   end

   // read_mbp, then write_ar, then the address bus
   always_comb begin
      if (strobes.rd_mbp) begin
         rd_idx = '0;
      end else if (strobes.war) begin
         rd_idx = ar_idx;
      end else begin
         rd_idx = ab_idx;
      end
   end

endmodule

// ==== design/mbu_decoder.sv ====
// MBU address decoder
// CU read and write codes plus the I/O window into active high strobes

`timescale 1ns/1ps

module mbu_decoder
   import mbu_pkg::*;
(
   input  cu_bus_t      cu,
   input  io_bus_t      io,
   output mbu_strobes_t strobes
);

   ////////////////////
   // CU decoding
   ////////////////////

   logic rd_mbp_hit;
   logic wr_mbp_hit;
   logic war_hit;

   // read_mbp, one exact code
   assign rd_mbp_hit = (cu.raddr == RD_MBP_CODE);

   // write_mbp, the lowest code bit is a don't care
   assign wr_mbp_hit = (cu.waddr.code[CU_ADDR_W-1:1] == WR_MBP_GROUP);

   // write_ar_xx, group field only
   // The sel field is picked up by the index select
   assign war_hit = (cu.waddr.ar.group == AR_GROUP);

   ////////////////////
   // I/O decoding
   ////////////////////

   logic window_hit;
   logic io_sel_hit;

   // AB[7]=0, AB[6:4]=000, AB[3]=1
   // Low bits are the register index and take no part here
   assign window_hit = (io.ab[7:IDX_W] == IO_BASE[7:IDX_W]);

   // System device space only
   assign io_sel_hit = window_hit & io.sysdev;

   ////////////////////
   // Strobe bundle
   ////////////////////

   always_comb begin
      strobes        = '0;
      strobes.rd_mbp = rd_mbp_hit;
      strobes.wr_mbp = wr_mbp_hit;
      strobes.war    = war_hit;
      strobes.io_sel = io_sel_hit;
      // OUT to a bank register
      strobes.io_wr  = io_sel_hit & io.w;
   end

endmodule

// ==== design/mbu_output.sv ====
// MBU output stage
// Enable flip-flop, power-on AEXT default, IBus and DB drive enables

`timescale 1ns/1ps

module mbu_output
   import mbu_pkg::*;
(
   input  logic              clk4,
   input  logic              reset,
   input  mbu_strobes_t      strobes,
   input  logic              io_r,
   input  logic [DATA_W-1:0] rd_data,
   input  logic              fp_ram_rom,
   output logic [DATA_W-1:0] aext,
   output logic [DATA_W-1:0] ibus_data,
   output logic              ibus_drive,
   output logic [DATA_W-1:0] db_data,
   output logic              db_drive
);

   ////////////////////
   // Enable flip-flop
   ////////////////////

   logic enabled;

   // Cleared by reset, set by the first OUT and then held
   always_ff @(posedge clk4) begin
      if (reset) begin
         enabled <= 1'b0;
      end else if (strobes.io_wr) begin
         enabled <= 1'b1;
      end
   end

   ////////////////////
   // Extended address
   ////////////////////

   logic [DATA_W-1:0] fp_default;

   // Front panel switch, 1 selects ROM at &80
   assign fp_default = fp_ram_rom ? FP_ROM_VALUE : FP_RAM_VALUE;

   // Always driven, the MBU is the only source
   assign aext = enabled ? rd_data : fp_default;

   ////////////////////
   // Bus drives
   ////////////////////

   // read_mbp puts AEXT on the IBus, never while reset is held
   assign ibus_data  = aext;
   assign ibus_drive = strobes.rd_mbp & ~reset;

   // IN from a bank register, also quiet in reset
   assign db_data  = aext;
   assign db_drive = strobes.io_sel & io_r & ~reset;

endmodule

// ==== design/mbu_pkg.sv ====
// Shared widths, address codes and bus types of the memory bank unit
// CU address union, CU and I/O bus structs, decoded strobe struct

package mbu_pkg;

   ////////////////////
   // Widths
   ////////////////////

   // Bank register and data bus width
   localparam int DATA_W    = 8;
   // Eight bank registers, MB0 is MBP
   localparam int NUM_REGS  = 8;
   localparam int IDX_W     = 3;
   // Microcode read and write unit address width
   localparam int CU_ADDR_W = 5;

   ////////////////////
   // Address codes
   ////////////////////

   // read_mbp on the CU read address
   localparam logic [CU_ADDR_W-1:0] RD_MBP_CODE  = 5'b01101;
   // write_mbp, both 01100 and 01101
   localparam logic [3:0]           WR_MBP_GROUP = 4'b0110;
   // The four write_ar codes 001xx
   localparam logic [2:0]           AR_GROUP     = 3'b001;

   // I/O window &008-&00F, low three bits pick the register
   localparam logic [7:0] IO_BASE = 8'h08;

   // Extended address while the unit is still disabled
   localparam logic [DATA_W-1:0] FP_ROM_VALUE = 8'h80;
   localparam logic [DATA_W-1:0] FP_RAM_VALUE = 8'h00;

   ////////////////////
   // Types
   ////////////////////

   typedef logic [IDX_W-1:0] reg_idx_t;

   // CU write address, seen whole or as write_ar group plus index
   typedef union packed {
      logic [CU_ADDR_W-1:0] code;
      struct packed {
         logic [2:0] group;
         logic [1:0] sel;
      } ar;
   } cu_waddr_u;

   // Control unit side of the MBU
   typedef struct packed {
      logic [CU_ADDR_W-1:0] raddr;
      cu_waddr_u            waddr;
      logic [2:0]           ir;
      // Requests IR[2:0] indexing on write_ar 11
      logic                 ir_idx;
   } cu_bus_t;

   // Address bus side, all flags active high
   typedef struct packed {
      logic [7:0] ab;
      logic       sysdev;
      logic       r;
      logic       w;
   } io_bus_t;

   // Decoded strobes, all active high
   typedef struct packed {
      logic rd_mbp;
      logic wr_mbp;
      logic war;
      logic io_sel;
      logic io_wr;
   } mbu_strobes_t;

endpackage

// ==== design/mbu_regfile.sv ====
// MBU bank register storage
// Eight 8-bit registers, clocked write and combinational read

`timescale 1ns/1ps

module mbu_regfile
   import mbu_pkg::*;
(
   input  logic              clk4,
   input  logic              wr_en,
   input  reg_idx_t          wr_idx,
   input  reg_idx_t          rd_idx,
   input  logic [DATA_W-1:0] wr_data,
   output logic [DATA_W-1:0] rd_data
);

   ////////////////////
   // Storage
   ////////////////////

   // MB0 is MBP, MB1 MBD, MB2 MBS
   // All registers come up as zero
   logic [DATA_W-1:0] regs [NUM_REGS] = '{default: '0};

   // One register per cycle
   // The new value is readable in the following cycle
   always_ff @(posedge clk4) begin
      if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   ////////////////////
   // Read port
   ////////////////////

   // Feeds AEXT directly, so no register here
   assign rd_data = regs[rd_idx];

endmodule

// ==== mbu.f ====
+incdir+tests
design/mbu_pkg.sv
design/mbu_decoder.sv
design/mbu_addr_select.sv
design/mbu_regfile.sv
design/mbu_output.sv
design/mbu.sv
tests/mbu_asserts.sv
tests/mbu_tb.sv

// ==== tests/mbu_asserts.sv ====
// Concurrent checks on the MBU output stage
// Reset quiet buses, IBus drive, power-on AEXT default

`timescale 1ns/1ps

module mbu_asserts
   import mbu_pkg::*;
(
   input logic              clk4,
   input logic              reset,
   input mbu_strobes_t      strobes,
   input logic              enabled,
   input logic              fp_ram_rom,
   input logic [DATA_W-1:0] aext,
   input logic              ibus_drive,
   input logic              db_drive
);

   int failures = 0;

   ////////////////////
   // Properties
   ////////////////////

   // No bus driven while reset is held
   quiet_in_reset: assert property (@(posedge clk4) reset |-> !ibus_drive && !db_drive)
      else begin
         $error("bus drive enable high during reset");
         failures++;
      end

   // IBus drive tracks read_mbp once out of reset
   ibus_follows_rd: assert property (@(posedge clk4) !reset |-> ibus_drive == strobes.rd_mbp)
      else begin
         $error("ibus_drive differs from rd_mbp");
         failures++;
      end

   // Switch default until the first OUT
   default_while_off: assert property (@(posedge clk4)
      !enabled |-> aext == (fp_ram_rom ? FP_ROM_VALUE : FP_RAM_VALUE))
      else begin
         $error("aext not at front panel default while disabled");
         failures++;
      end

endmodule

bind mbu_output mbu_asserts u_asserts (
   .clk4       (clk4),
   .reset      (reset),
   .strobes    (strobes),
   .enabled    (enabled),
   .fp_ram_rom (fp_ram_rom),
   .aext       (aext),
   .ibus_drive (ibus_drive),
   .db_drive   (db_drive)
);

// ==== tests/mbu_model.svh ====
// Reference model of the MBU bank registers, enable flag and read paths
// Included inside the testbench module

`ifndef MBU_MODEL_SVH
`define MBU_MODEL_SVH

// Bank registers power up as zero and reset leaves them alone
logic [DATA_W-1:0] ref_regs [NUM_REGS] = '{default: '0};
logic              ref_enabled = 1'b0;
logic              ref_ir_idx  = 1'b0;

// Strobes taken straight from the CU and I/O address maps
function automatic mbu_strobes_t decode_ref(cu_bus_t c, io_bus_t i);
   mbu_strobes_t s;
   s.rd_mbp = (c.raddr == 5'b01101);
   s.wr_mbp = (c.waddr.code == 5'b01100) || (c.waddr.code == 5'b01101);
   s.war    = (c.waddr.code >= 5'b00100) && (c.waddr.code <= 5'b00111);
   s.io_sel = (i.ab >= 8'h08) && (i.ab <= 8'h0f) && i.sysdev;
   s.io_wr  = s.io_sel && i.w;
   return s;
endfunction

// read_mbp first, then write_ar, then the address bus
function automatic reg_idx_t pick_rd_idx(cu_bus_t c, io_bus_t i);
   mbu_strobes_t s;
   s = decode_ref(c, i);
   if (s.rd_mbp) return 3'd0;
   if (!s.war) return i.ab[2:0];
   // Codes 00..10 name MBP, MBD, MBS directly
   if (c.waddr.code[1:0] != 2'b11) return reg_idx_t'(c.waddr.code[1:0]);
   return ref_ir_idx ? c.ir : 3'd3;
endfunction

function automatic logic [DATA_W-1:0] predicted_aext(cu_bus_t c, io_bus_t i, logic fp);
   if (!ref_enabled) return fp ? 8'h80 : 8'h00;
   return ref_regs[pick_rd_idx(c, i)];
endfunction

// State change at one rising edge, OUT beats write_mbp
task automatic advance_model(cu_bus_t c, io_bus_t i, logic [DATA_W-1:0] d, logic rst);
   mbu_strobes_t s;
   s = decode_ref(c, i);
   if (s.io_wr) ref_regs[i.ab[2:0]] = d;
   else if (s.wr_mbp) ref_regs[0] = d;
   ref_enabled = rst ? 1'b0 : (ref_enabled || s.io_wr);
   ref_ir_idx  = rst ? 1'b0 : c.ir_idx;
endtask

`endif

// ==== tests/mbu_tb.sv ====
// MBU testbench with clock, reset, directed and LFSR random stimulus
// Per-cycle comparison against the included reference model

`timescale 1ns/1ps

module mbu_tb
   import mbu_pkg::*;
();

   localparam int      WAIT_LIMIT = 16;
   localparam cu_bus_t CU_IDLE    = '0;
   localparam io_bus_t IO_IDLE    = '0;

   logic              clk4       = 1'b0;
   logic              reset      = 1'b1;
   cu_bus_t           cu         = '0;
   io_bus_t           io         = '0;
   logic [DATA_W-1:0] wr_data    = '0;
   logic              fp_ram_rom = 1'b1;
   logic [DATA_W-1:0] aext, ibus_data, db_data;
   logic              ibus_drive, db_drive;

   int          checks   = 0;
   int          errors   = 0;
   int          timeouts = 0;
   logic [15:0] lfsr     = 16'd44967;

   `include "mbu_model.svh"

   mbu UUT (
      .clk4 (clk4), .reset (reset), .cu (cu), .io (io), .wr_data (wr_data),
      .fp_ram_rom (fp_ram_rom), .aext (aext), .ibus_data (ibus_data),
      .ibus_drive (ibus_drive), .db_data (db_data), .db_drive (db_drive)
   );

   initial begin
      forever #50 clk4 = ~clk4;
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Galois LFSR, one step per bit taken
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         v    = {v[14:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hb400 : 16'h0000);
      end
      return v;
   endfunction

   function automatic cu_bus_t cu_of(logic [4:0] ra, logic [4:0] wa, logic [2:0] ir, logic x);
      cu_bus_t c;
      c.raddr      = ra;
      c.waddr.code = wa;
      c.ir         = ir;
      c.ir_idx     = x;
      return c;
   endfunction

   task automatic check_aext(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: aext is %h, expected %h", $time, got, exp);
      end
   endtask

   // Data only matters while the bus is driven
   task automatic check_bus(input string bus, input logic [DATA_W-1:0] got,
                            input logic drv, input logic [DATA_W-1:0] exp, input logic exp_drv);
      checks++;
      if (drv !== exp_drv || (exp_drv && got !== exp)) begin
         errors++;
         $display("MISMATCH at %0t: %s data %h drive %b, expected %h drive %b",
                  $time, bus, got, drv, exp, exp_drv);
      end
   endtask

   // Bus drives stay low for as long as reset is held
   task automatic compare_outputs();
      mbu_strobes_t      s;
      logic [DATA_W-1:0] exp;
      s   = decode_ref(cu, io);
      exp = predicted_aext(cu, io, fp_ram_rom);
      check_aext(aext, exp);
      check_bus("ibus", ibus_data, ibus_drive, exp, s.rd_mbp && !reset);
      check_bus("db", db_data, db_drive, exp, s.io_sel && io.r && !reset);
   endtask

   // Model takes the edge's inputs, then the next inputs go out
   // Outputs are compared at the falling edge
   task automatic step_cycle(input cu_bus_t c, input io_bus_t i, input logic [DATA_W-1:0] d,
                             input logic fp, input logic rst);
      @(posedge clk4);
      advance_model(cu, io, wr_data, reset);
      cu         <= c;
      io         <= i;
      wr_data    <= d;
      fp_ram_rom <= fp;
      reset      <= rst;
      @(negedge clk4);
      compare_outputs();
   endtask

   task automatic await_drive(input logic use_db);
      int n;
      n = 0;
      while ((use_db ? db_drive : ibus_drive) !== 1'b1 && n < WAIT_LIMIT) begin
         step_cycle(cu, io, wr_data, fp_ram_rom, reset);
         n++;
      end
      if ((use_db ? db_drive : ibus_drive) !== 1'b1) begin
         $display("Timeout: %s drive enable never rose", use_db ? "db" : "ibus");
         timeouts++;
      end
   endtask

   ////////////////////
   // Sequences
   ////////////////////

   task automatic run_directed();
      int n;
      // Switch default, write_mbp alone does not enable
      step_cycle(CU_IDLE, IO_IDLE, 8'h00, 1'b0, 1'b0);
      step_cycle(cu_of(5'b0, 5'b01100, 3'd0, 1'b0), IO_IDLE, 8'h5a, 1'b0, 1'b0);
      step_cycle(CU_IDLE, IO_IDLE, 8'h00, 1'b1, 1'b0);
      // OUT then IN across the whole window
      for (n = 0; n < 8; n++) begin
         step_cycle(CU_IDLE, io_bus_t'({8'h08 + 8'(n), 3'b101}), 8'h31 + 8'(n * 29), 1'b1, 1'b0);
         step_cycle(CU_IDLE, io_bus_t'({8'h08 + 8'(n), 3'b110}), 8'h00, 1'b1, 1'b0);
         await_drive(1'b1);
         if (timeouts != 0) return;
      end
      // Outside the window, then sysdev low
      step_cycle(CU_IDLE, io_bus_t'({8'h18, 3'b101}), 8'hff, 1'b1, 1'b0);
      step_cycle(CU_IDLE, io_bus_t'({8'h09, 3'b001}), 8'hee, 1'b1, 1'b0);
      step_cycle(CU_IDLE, io_bus_t'({8'h09, 3'b110}), 8'h00, 1'b1, 1'b0);
      // write_mbp then read_mbp
      step_cycle(cu_of(5'b0, 5'b01101, 3'd0, 1'b0), IO_IDLE, 8'hc3, 1'b1, 1'b0);
      step_cycle(cu_of(5'b01101, 5'b0, 3'd0, 1'b0), IO_IDLE, 8'h00, 1'b1, 1'b0);
      await_drive(1'b0);
      if (timeouts != 0) return;
      // write_ar 00..11 without, then with auto-index
      for (n = 0; n < 4; n++) begin
         step_cycle(cu_of(5'b0, 5'b00100 + 5'(n), 3'd5, 1'b0), IO_IDLE, 8'h00, 1'b1, 1'b0);
      end
      step_cycle(cu_of(5'b0, 5'b0, 3'd5, 1'b1), IO_IDLE, 8'h00, 1'b1, 1'b0);
      step_cycle(cu_of(5'b0, 5'b00111, 3'd5, 1'b0), IO_IDLE, 8'h00, 1'b1, 1'b0);
      // write_mbp and OUT together, then read both targets
      step_cycle(cu_of(5'b0, 5'b01100, 3'd0, 1'b0), io_bus_t'({8'h0a, 3'b101}), 8'h99, 1'b1, 1'b0);
      step_cycle(cu_of(5'b01101, 5'b0, 3'd0, 1'b0), IO_IDLE, 8'h00, 1'b1, 1'b0);
      step_cycle(CU_IDLE, io_bus_t'({8'h0a, 3'b110}), 8'h00, 1'b1, 1'b0);
   endtask

   // Addresses biased toward the defined codes
   task automatic run_random(input int cycles);
      logic [4:0] ra, wa;
      logic [7:0] ab, d;
      logic [2:0] ir, flags;
      logic       x;
      for (int n = 0; n < cycles; n++) begin
         ra = (take_bits(2) == 0) ? 5'b01101 : 5'(take_bits(5));
         case (take_bits(2))
            2'd0:    wa = 5'b00100 | 5'(take_bits(2));
            2'd1:    wa = 5'b01100 | 5'(take_bits(1));
            default: wa = 5'(take_bits(5));
         endcase
         ab    = (take_bits(1) == 0) ? (8'h08 | 8'(take_bits(3))) : 8'(take_bits(8));
         ir    = 3'(take_bits(3));
         x     = take_bits(1) == 1;
         flags = {take_bits(2) != 0, 2'(take_bits(2))};
         d     = 8'(take_bits(8));
         step_cycle(cu_of(ra, wa, ir, x), io_bus_t'({ab, flags}), d, 1'b1, 1'b0);
      end
   endtask

   initial begin
      // read_mbp and IN requested all through reset
      for (int k = 0; k < 8; k++) begin
         step_cycle(cu_of(5'b01101, 5'b0, 3'd0, 1'b0), io_bus_t'({8'h08 + 8'(k), 3'b110}),
                    8'h00, 1'b1, k < 7);
      end
      run_directed();
      if (timeouts == 0) run_random(500);
      $display("Done: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
               checks, errors, timeouts, UUT.u_output.u_asserts.failures);
      if (errors == 0 && timeouts == 0 && UUT.u_output.u_asserts.failures == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
